/* source/fofb_pkg.sv */
// fast orbit feedback UDP client, shared definitions
// types, packet layout constants and the header byte rule
// used by both the setpoint transmitter and the readback parser

package fofb_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] word_t;
  typedef logic [10:0] frame_len_t;   // enough for a 1500 byte frame
  typedef logic [63:0] nonce_t;
  typedef logic [3:0]  command_t;
  typedef logic [6:0]  byte_sel_t;    // counts down through header, then entries

  typedef enum logic {
    idle,
    sending
  } tx_state_t;

  ////////////////////////////////////////////////////////////
  // packet layout, multibyte fields go out MSB first
  localparam byte_t     MAGIC_HI     = 8'h76;
  localparam byte_t     MAGIC_LO     = 8'h31;
  localparam int        HEADER_BYTES = 12;   // magic, command, nonce
  localparam int        ENTRY_BYTES  = 6;    // supply number, value
  localparam byte_sel_t SEL_FIRST    = byte_sel_t'(HEADER_BYTES + ENTRY_BYTES - 1);
  localparam byte_sel_t SEL_ENTRY    = byte_sel_t'(ENTRY_BYTES - 1);
  localparam int        UDP_PORT     = 30721;

  // expected byte for header selectors 17 down to 6
  function automatic byte_t header_byte(byte_sel_t sel, command_t cmd, nonce_t nonce);
    byte_t value;
    int    idx;
    idx   = int'(sel) - int'(SEL_ENTRY) - 1;   // nonce byte, 0 is lsb
    value = 8'h00;                             // also the pad before command
    if (sel == SEL_FIRST) begin
      value = MAGIC_HI;
    end else if (sel == SEL_FIRST - 1) begin
      value = MAGIC_LO;
    end else if (sel == SEL_FIRST - 3) begin
      value = byte_t'(cmd);
    end else if (idx >= 0 && idx < 8) begin
      value = nonce[8*idx +: 8];
    end
    return value;
  endfunction

endpackage

/* source/setpoint_buffer.sv */
// setpoint buffer
// stashes one stream of corrector setpoints in a dual-port RAM and hands it
// to the transmitter with a toggle; streams arriving while busy are tossed

module setpoint_buffer #(
  parameter int max_supplies = 32
) (
  input  logic                            ethClk,
  input  logic                            rst_n,
  input  fofb_pkg::word_t                 s_tdata,
  input  logic                            s_tvalid,
  input  logic                            s_tlast,
  input  logic                            done_toggle,
  input  logic [$clog2(max_supplies)-1:0] rd_addr,
  output fofb_pkg::word_t                 rd_data,
  output logic                            load_toggle,
  output logic [$clog2(max_supplies)-1:0] last_index
);

  import fofb_pkg::*;

  localparam int addr_w = $clog2(max_supplies);

  typedef logic [addr_w-1:0] addr_t;

  word_t mem [max_supplies];
  addr_t wr_addr;
  logic  toss;        // dropping the rest of a stream
  logic  tx_free;     // no packet pending
  logic  accept;

  assign tx_free = (load_toggle == done_toggle);
  assign accept  = s_tvalid && !toss && tx_free;

  ////////////////////////////////////////////////////////////
  // payload RAM, read port registered
  always_ff @(posedge ethClk) begin
    if (accept) begin
      mem[wr_addr] <= s_tdata;
    end
    rd_data <= mem[rd_addr];
  end

  ////////////////////////////////////////////////////////////
  // stream bookkeeping
  always_ff @(posedge ethClk) begin
    if (!rst_n) begin
      wr_addr     <= '0;
      toss        <= 1'b0;
      load_toggle <= 1'b0;
    end else if (s_tvalid) begin
      if (toss) begin
        if (s_tlast) begin
          toss <= 1'b0;                   // tossed stream is over
        end
      end else if (tx_free) begin
        if (s_tlast) begin
          wr_addr     <= '0;
          load_toggle <= !load_toggle;    // hand stream to transmitter
        end else begin
          wr_addr <= wr_addr + 1'b1;
        end
      end else if (!s_tlast) begin
        toss <= 1'b1;                     // single-word stream needs no flag
      end
    end
  end

  // index of the final word, held for the packet length
  always_ff @(posedge ethClk) begin
    if (accept && s_tlast) begin
      last_index <= wr_addr;
    end
  end

  // streams longer than the buffer would overwrite stored words
  wr_addr_in_range: assert property (
    @(posedge ethClk) disable iff (!rst_n)
    accept && !s_tlast |-> int'(wr_addr) < max_supplies - 1
  );

endmodule

/* source/setpoint_tx.sv */
// setpoint transmitter
// numbers each packet and feeds the UDP client transmit strobes one byte at
// a time: magic, command, nonce, then one 6-byte entry per supply

module setpoint_tx #(
  parameter int max_supplies = 32
) (
  input  logic                            ethClk,
  input  logic                            rst_n,
  input  fofb_pkg::command_t              command,
  input  logic                            load_toggle,
  input  logic [$clog2(max_supplies)-1:0] last_index,
  input  fofb_pkg::word_t                 rd_data,
  output logic [$clog2(max_supplies)-1:0] rd_addr,
  output logic                            done_toggle,
  output fofb_pkg::nonce_t                nonce,
  input  logic                            ack,
  input  logic                            strobe_tx,
  input  logic                            warn,
  output logic                            req,
  output fofb_pkg::frame_len_t            length,
  output fofb_pkg::byte_t                 data_tx
);

  import fofb_pkg::*;

  localparam int addr_w = $clog2(max_supplies);

  tx_state_t state;
  byte_sel_t sel;
  byte_t     supply_num;
  logic      start;

  assign start   = (state == idle) && (load_toggle != done_toggle);
  assign rd_addr = supply_num[addr_w-1:0];

  ////////////////////////////////////////////////////////////
  // outgoing byte mux
  always_comb begin
    if (sel > SEL_ENTRY) begin
      data_tx = header_byte(sel, command, nonce);
    end else begin
      case (sel)
        SEL_ENTRY: data_tx = 8'h00;         // supply number hi
        7'd4:      data_tx = supply_num;
        7'd3:      data_tx = rd_data[31:24];
        7'd2:      data_tx = rd_data[23:16];
        7'd1:      data_tx = rd_data[15:8];
        default:   data_tx = rd_data[7:0];
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // packet sequencer
  always_ff @(posedge ethClk) begin
    if (!rst_n) begin
      state       <= idle;
      req         <= 1'b0;
      done_toggle <= 1'b0;
      nonce       <= '0;
      sel         <= SEL_FIRST;
      supply_num  <= '0;
    end else begin
      case (state)
        idle: begin
          sel        <= SEL_FIRST;
          supply_num <= '0;
          if (start) begin
            nonce <= nonce + 1'b1;          // first packet carries 1
            req   <= 1'b1;
            state <= sending;
          end
        end
        sending: begin
          if (ack) begin
            req <= 1'b0;
          end
          if (strobe_tx) begin
            if (!warn) begin
              state       <= idle;          // stack closed the packet
              done_toggle <= !done_toggle;
            end else if (sel == '0) begin
              sel        <= SEL_ENTRY;      // on to the next supply
              supply_num <= supply_num + 1'b1;
            end else begin
              sel <= sel - 1'b1;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // header plus one entry per stored word
  always_ff @(posedge ethClk) begin
    if (start) begin
      length <= frame_len_t'(HEADER_BYTES + ENTRY_BYTES)
              + frame_len_t'(ENTRY_BYTES) * frame_len_t'(last_index);
    end
  end

  // a request stands only while its packet is open
  req_only_sending: assert property (
    @(posedge ethClk) disable iff (!rst_n)
    req |-> state == sending
  );

endmodule

/* source/readback_rx.sv */
// readback receiver
// parses client bytes of a returned packet, flags header mismatches and
// emits one value with its supply number per 6-byte entry

module readback_rx (
  input  logic               ethClk,
  input  logic               rst_n,
  input  fofb_pkg::command_t command,
  input  fofb_pkg::nonce_t   nonce,
  input  logic               ready,
  input  logic               strobe_rx,
  input  fofb_pkg::byte_t    data_rx,
  output fofb_pkg::word_t    rx_data,
  output fofb_pkg::byte_t    rx_user,
  output logic               rx_valid,
  output logic               rx_header_bad
);

  import fofb_pkg::*;

  byte_sel_t   sel;
  byte_t       expected;
  byte_t       user_hold;    // supply number of the current entry
  logic [23:0] data_hold;    // upper three value bytes
  logic        take;

  assign expected = header_byte(sel, command, nonce);
  assign take     = strobe_rx && !ready;

  ////////////////////////////////////////////////////////////
  // selector, header check, output pulse
  always_ff @(posedge ethClk) begin
    if (!rst_n) begin
      sel           <= SEL_FIRST;
      rx_valid      <= 1'b0;
      rx_header_bad <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (ready) begin
        sel           <= SEL_FIRST;         // new packet
        rx_header_bad <= 1'b0;
      end else if (strobe_rx) begin
        if (sel == '0) begin
          sel      <= SEL_ENTRY;
          rx_valid <= 1'b1;                 // last byte of entry
        end else begin
          sel <= sel - 1'b1;
        end
        if (sel > SEL_ENTRY && data_rx != expected) begin
          rx_header_bad <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // entry assembly, byte 5 is the unused supply hi byte
  always_ff @(posedge ethClk) begin
    if (take) begin
      case (sel)
        7'd4: user_hold         <= data_rx;
        7'd3: data_hold[23:16]  <= data_rx;
        7'd2: data_hold[15:8]   <= data_rx;
        7'd1: data_hold[7:0]    <= data_rx;
        7'd0: begin
          rx_user <= user_hold;
          rx_data <= {data_hold, data_rx};
        end
        default: begin
        end
      endcase
    end
  end

  // the stack never delivers a byte on the packet start pulse
  ready_not_with_byte: assert property (
    @(posedge ethClk) disable iff (!rst_n)
    ready |-> !strobe_rx
  );

endmodule

/* source/fofb_udp_client.sv */
// fast orbit feedback UDP client
// setpoint streams go out as numbered packets over the UDP client strobes,
// returned readback packets are checked and split into per-supply values

module fofb_udp_client #(
  parameter int max_supplies = 32
) (
  input  logic                 ethClk,
  input  logic                 rst_n,
  input  fofb_pkg::command_t   command,

  input  fofb_pkg::word_t      s_tdata,
  input  logic                 s_tvalid,
  input  logic                 s_tlast,

  output logic                 req,
  output fofb_pkg::frame_len_t length,
  input  logic                 ack,
  input  logic                 strobe_tx,
  input  logic                 warn,
  output fofb_pkg::byte_t      data_tx,

  input  logic                 ready,
  input  logic                 strobe_rx,
  input  fofb_pkg::byte_t      data_rx,

  output fofb_pkg::word_t      rx_data,
  output fofb_pkg::byte_t      rx_user,
  output logic                 rx_valid,
  output logic                 rx_header_bad
);

  import fofb_pkg::*;

  localparam int addr_w = $clog2(max_supplies);

  logic [addr_w-1:0] rd_addr;
  logic [addr_w-1:0] last_index;
  word_t             rd_data;
  logic              load_toggle;
  logic              done_toggle;
  nonce_t            nonce;        // packet number, also checked on readback

  ////////////////////////////////////////////////////////////
  // setpoint path
  setpoint_buffer #(
    .max_supplies (max_supplies)
  ) u_buffer (
    .ethClk      (ethClk),
    .rst_n       (rst_n),
    .s_tdata     (s_tdata),
    .s_tvalid    (s_tvalid),
    .s_tlast     (s_tlast),
    .done_toggle (done_toggle),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .load_toggle (load_toggle),
    .last_index  (last_index)
  );

  setpoint_tx #(
    .max_supplies (max_supplies)
  ) u_tx (
    .ethClk      (ethClk),
    .rst_n       (rst_n),
    .command     (command),
    .load_toggle (load_toggle),
    .last_index  (last_index),
    .rd_data     (rd_data),
    .rd_addr     (rd_addr),
    .done_toggle (done_toggle),
    .nonce       (nonce),
    .ack         (ack),
    .strobe_tx   (strobe_tx),
    .warn        (warn),
    .req         (req),
    .length      (length),
    .data_tx     (data_tx)
  );

  ////////////////////////////////////////////////////////////
  // readback path
  readback_rx u_rx (
    .ethClk        (ethClk),
    .rst_n         (rst_n),
    .command       (command),
    .nonce         (nonce),
    .ready         (ready),
    .strobe_rx     (strobe_rx),
    .data_rx       (data_rx),
    .rx_data       (rx_data),
    .rx_user       (rx_user),
    .rx_valid      (rx_valid),
    .rx_header_bad (rx_header_bad)
  );

endmodule

/* bench/udp_stack_stub.sv */
// UDP stack stand-in for the client testbench
// acknowledges each request, collects the transmitted bytes and loops them
// back into the receive port, optionally with one header bit flipped

module udp_stack_stub (
  input  logic        ethClk,
  input  logic        rst_n,
  input  logic        req,
  input  logic [10:0] length,
  input  logic [7:0]  data_tx,
  input  logic        corrupt,
  output logic        ack,
  output logic        strobe_tx,
  output logic        warn,
  output logic        ready,
  output logic        strobe_rx,
  output logic [7:0]  data_rx,
  output logic        busy
);

  timeunit 1ns;
  timeprecision 100ps;

  import fofb_pkg::*;

  logic [7:0] bytes [$];
  int         len;

  initial begin
    ack       = 1'b0;
    strobe_tx = 1'b0;
    warn      = 1'b0;
    ready     = 1'b0;
    strobe_rx = 1'b0;
    data_rx   = 8'h00;
    busy      = 1'b0;
    forever begin
      @(posedge ethClk);
      #1;
      if (rst_n && req) begin
        busy = 1'b1;
        len  = int'(length);
        ack  = 1'b1;
        @(posedge ethClk);
        #1;
        ack = 1'b0;
        bytes.delete();
        for (int i = 0; i < len; i++) begin
          strobe_tx = 1'b1;
          warn      = 1'b1;
          bytes.push_back(data_tx);          // byte taken on the next edge
          @(posedge ethClk);
          #1;
        end
        warn = 1'b0;                         // closing strobe
        @(posedge ethClk);
        #1;
        strobe_tx = 1'b0;
        $display("udp stub: %0d byte packet to port %0d", len, UDP_PORT);

        ////////////////////////////////////////////////////////////
        // loop the packet back into the receiver
        ready = 1'b1;
        @(posedge ethClk);
        #1;
        ready = 1'b0;
        for (int i = 0; i < len; i++) begin
          strobe_rx = 1'b1;
          data_rx   = (corrupt && i == 2) ? bytes[i] ^ 8'h04 : bytes[i];
          @(posedge ethClk);
          #1;
        end
        strobe_rx = 1'b0;
        repeat (2) @(posedge ethClk);        // let the last entry settle
        #1;
        busy = 1'b0;
      end
    end
  end

endmodule

/* bench/fofb_tb.sv */
// testbench for the fast orbit feedback UDP client
// streams setpoints in, lets the stack stand-in loop each packet back and
// checks both directions with concurrent assertions

module fofb_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int max_supplies = 8;

  logic        ethClk, rst_n, corrupt, busy;
  logic [3:0]  command;
  logic [31:0] s_tdata, rx_data;
  logic        s_tvalid, s_tlast, rx_valid, rx_header_bad;
  logic        req, ack, strobe_tx, warn, ready, strobe_rx;
  logic [10:0] length;
  logic [7:0]  data_tx, data_rx, rx_user;

  logic [31:0] exp_words [max_supplies];   // words of the packet on the wire
  int          exp_pkt, exp_len, exp_count;
  int          tx_idx, rx_idx;
  int          errors, timeouts;
  integer      seed;

  fofb_udp_client #(.max_supplies (max_supplies)) uut (.*);

  udp_stack_stub stack (.*);

  always #10 ethClk = ~ethClk;

  // byte idx of the current packet, from the packet layout
  function automatic logic [7:0] tx_byte_model(int idx, int pkt, logic [3:0] cmd);
    logic [63:0] nonce_v;
    logic [7:0]  value;
    int          entry;
    int          pos;
    nonce_v = 64'(pkt);
    entry   = (idx - 12) / 6;
    pos     = (idx - 12) % 6;
    if (idx < 4) begin
      value = (idx == 0) ? 8'h76 : (idx == 1) ? 8'h31 : (idx == 2) ? 8'h00 : {4'h0, cmd};
    end else if (idx < 12) begin
      value = nonce_v[8*(11-idx) +: 8];    // nonce msb first
    end else if (pos == 0) begin
      value = 8'h00;
    end else if (pos == 1) begin
      value = 8'(entry);
    end else begin
      value = exp_words[entry][8*(5-pos) +: 8];
    end
    return value;
  endfunction

  // byte and entry positions within the current packet
  always @(posedge ethClk) begin
    if (!rst_n) begin
      tx_idx <= 0;
      rx_idx <= 0;
    end else begin
      if (strobe_tx) begin
        tx_idx <= warn ? tx_idx + 1 : 0;   // closing strobe restarts
      end
      if (ready) begin
        rx_idx <= 0;
      end else if (rx_valid) begin
        rx_idx <= rx_idx + 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  tx_length: assert property (@(posedge ethClk) disable iff (!rst_n)
      $rose(req) |-> length == 11'(exp_len))
    else begin
      errors++;
      $display("[ERROR] %0t length: expected %0d, got %0d", $time, exp_len, $sampled(length));
    end

  tx_req_drop: assert property (@(posedge ethClk) disable iff (!rst_n)
      ack |=> !req)
    else begin
      errors++;
      $display("[ERROR] %0t req: expected 0, got %b", $time, $sampled(req));
    end

  tx_byte: assert property (@(posedge ethClk) disable iff (!rst_n)
      strobe_tx && warn |-> data_tx == tx_byte_model(tx_idx, exp_pkt, command))
    else begin
      errors++;
      $display("[ERROR] %0t data_tx: expected %h, got %h", $time,
               tx_byte_model($sampled(tx_idx), exp_pkt, command), $sampled(data_tx));
    end

  rx_user_ok: assert property (@(posedge ethClk) disable iff (!rst_n)
      rx_valid |-> rx_user == 8'(rx_idx))
    else begin
      errors++;
      $display("[ERROR] %0t rx_user: expected %0d, got %0d", $time, $sampled(rx_idx),
               $sampled(rx_user));
    end

  rx_data_ok: assert property (@(posedge ethClk) disable iff (!rst_n)
      rx_valid |-> rx_data == exp_words[rx_idx])
    else begin
      errors++;
      $display("[ERROR] %0t rx_data: expected %h, got %h", $time,
               exp_words[$sampled(rx_idx)], $sampled(rx_data));
    end

  rx_all_entries: assert property (@(posedge ethClk) disable iff (!rst_n)
      $fell(busy) |-> rx_idx == exp_count)
    else begin
      errors++;
      $display("[ERROR] %0t rx_valid count: expected %0d, got %0d", $time, exp_count,
               $sampled(rx_idx));
    end

  bad_only_corrupt: assert property (@(posedge ethClk) disable iff (!rst_n)
      $rose(rx_header_bad) |-> corrupt)
    else begin
      errors++;
      $display("[ERROR] %0t rx_header_bad: expected 0, got 1", $time);
    end

  bad_on_corrupt: assert property (@(posedge ethClk) disable iff (!rst_n)
      $fell(corrupt) |-> rx_header_bad)
    else begin
      errors++;
      $display("[ERROR] %0t rx_header_bad: expected 1, got 0", $time);
    end

  ////////////////////////////////////////////////////////////
  // stimulus
  task automatic send_stream(input int n_words, input bit keep);
    logic [31:0] word;
    if (keep) begin
      exp_pkt   = exp_pkt + 1;
      exp_len   = 18 + 6 * (n_words - 1);
      exp_count = n_words;
    end
    for (int i = 0; i < n_words; i++) begin
      word = $random(seed);
      if (keep) begin
        exp_words[i] = word;
      end
      @(posedge ethClk);
      #1;
      s_tdata  = word;
      s_tvalid = 1'b1;
      s_tlast  = (i == n_words - 1);
    end
    @(posedge ethClk);
    #1;
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
  endtask

  task automatic wait_busy(input logic level, input int limit);
    int n;
    n = 0;
    do begin
      @(posedge ethClk);
      n++;
    end while (timeouts == 0 && busy !== level && n < limit);
    #1;
    if (timeouts == 0 && busy !== level) begin
      timeouts++;
      $display("timeout: stack stub did not go %s within %0d cycles",
               level ? "busy" : "idle", limit);
    end
  endtask

  task automatic send_and_check(input int n_words);
    send_stream(n_words, 1'b1);
    wait_busy(1'b1, 50);
    wait_busy(1'b0, 400);
  endtask

  task automatic end_run();
    $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
  endtask

  initial begin
    ethClk   = 1'b0;
    rst_n    = 1'b0;
    command  = 4'h5;
    s_tdata  = '0;
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    corrupt  = 1'b0;
    exp_pkt  = 0;
    exp_len  = 0;
    errors   = 0;
    timeouts = 0;
    seed     = 32'hded3;
    repeat (3) @(posedge ethClk);
    #1;
    rst_n = 1'b1;
    send_and_check(4);
    command = 4'ha;
    send_and_check(max_supplies);          // full buffer
    send_and_check(1);
    corrupt = 1'b1;
    send_and_check(3);
    corrupt = 1'b0;
    send_stream(5, 1'b1);
    send_stream(3, 1'b0);                  // arrives while pending, tossed
    wait_busy(1'b1, 50);
    wait_busy(1'b0, 400);
    send_and_check(2);
    repeat (4) @(posedge ethClk);
    end_run();
    $finish;
  end

endmodule

/* tb.f */
source/fofb_pkg.sv
source/setpoint_buffer.sv
source/setpoint_tx.sv
source/readback_rx.sv
source/fofb_udp_client.sv
bench/udp_stack_stub.sv
bench/fofb_tb.sv

/* Bender.yml */
package:
  name: fofb_udp_client

sources:
  - source/fofb_pkg.sv
  - source/setpoint_buffer.sv
  - source/setpoint_tx.sv
  - source/readback_rx.sv
  - source/fofb_udp_client.sv
  - target: test
    files:
      - bench/udp_stack_stub.sv
      - bench/fofb_tb.sv
